//--- hdl/cache_core.sv
// Direct-mapped write-through cache core
// Init sweep, tag lookup, miss fill and in-order kernel responses
`timescale 1ns/10ps

module cache_core import cache_pkg::*; #(
  parameter int NUM_LINES = 16                // Lines, power of two
) (
  input  logic              ap_clk,
  input  logic              areset_core,
  input  logic              q_valid,
  input  cache_op_e         q_op,
  input  logic [ADDR_W-1:0] q_addr,
  input  logic [DATA_W-1:0] q_wdata,
  output logic              q_pop,
  output logic              cache_setup,
  output logic              mem_issue,
  output cache_op_e         mem_issue_op,
  output logic [ADDR_W-1:0] mem_issue_addr,
  output logic [DATA_W-1:0] mem_issue_wdata,
  input  logic              mem_can_issue,
  input  logic              fill_valid,
  input  logic [DATA_W-1:0] fill_data,
  output logic              resp_valid,
  output cache_op_e         resp_op,
  output logic [DATA_W-1:0] resp_rdata
);

  localparam int IDX_W = $clog2(NUM_LINES);
  localparam int TAG_W = ADDR_W - IDX_W;

  core_state_e       state;
  core_state_e       state_next;
  logic [IDX_W-1:0]  init_idx;                // Sweep position

  // ------------------------------------------------
  // Line arrays and request registers
  // ------------------------------------------------
  logic [NUM_LINES-1:0] line_valid;
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [DATA_W-1:0]    data_mem [NUM_LINES];

  cache_op_e         op_r;                    // Request in flight
  logic [ADDR_W-1:0] addr_r;
  logic [DATA_W-1:0] wdata_r;
  logic [DATA_W-1:0] rdata_r;                 // Response data

  logic [IDX_W-1:0]  line_idx;
  logic [TAG_W-1:0]  line_tag;
  logic              hit;
  logic              do_fill;

  assign line_idx = addr_r[IDX_W-1:0];        // Low bits select the line
  assign line_tag = addr_r[ADDR_W-1:IDX_W];
  assign hit      = line_valid[line_idx] && (tag_mem[line_idx] == line_tag);
  assign do_fill  = (state == ST_MEM_WAIT) && fill_valid;

  // ------------------------------------------------
  // FSM
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_core) begin
      state    <= ST_INIT;
      init_idx <= '0;
    end else begin
      state <= state_next;
      if (state == ST_INIT) init_idx <= init_idx + 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_INIT:      if (init_idx == IDX_W'(NUM_LINES - 1)) state_next = ST_IDLE;
      ST_IDLE:      if (q_valid) state_next = ST_LOOKUP;
      ST_LOOKUP:    state_next = (op_r == OP_READ && hit) ? ST_RESPOND : ST_MEM_ISSUE;
      ST_MEM_ISSUE: begin
        if (mem_can_issue) begin                   // Stalls here with no memory credit
          state_next = (op_r == OP_WRITE) ? ST_RESPOND : ST_MEM_WAIT;
        end
      end
      ST_MEM_WAIT:  if (fill_valid) state_next = ST_RESPOND;
      ST_RESPOND:   state_next = ST_IDLE;
      default:      state_next = ST_INIT;
    endcase
  end

  // Latch the popped request and the data to return
  always_ff @(posedge ap_clk) begin
    if (q_pop) begin
      op_r    <= q_op;
      addr_r  <= q_addr;
      wdata_r <= q_wdata;
    end
    if (state == ST_LOOKUP && hit) rdata_r <= data_mem[line_idx];
    if (do_fill)                   rdata_r <= fill_data;
  end

  // Sweep clears one line per cycle, fills mark the line valid
  always_ff @(posedge ap_clk) begin
    if (state == ST_INIT) line_valid[init_idx] <= 1'b0;
    else if (do_fill)     line_valid[line_idx] <= 1'b1;
  end

  always_ff @(posedge ap_clk) begin
    if (state == ST_LOOKUP && op_r == OP_WRITE && hit) begin
      data_mem[line_idx] <= wdata_r;               // Write hit updates the line
    end
    if (do_fill) begin
      data_mem[line_idx] <= fill_data;             // Read miss installs the word
      tag_mem[line_idx]  <= line_tag;
    end
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  assign cache_setup     = (state == ST_INIT);
  assign q_pop           = (state == ST_IDLE) && q_valid;
  assign mem_issue       = (state == ST_MEM_ISSUE) && mem_can_issue;
  assign mem_issue_op    = op_r;
  assign mem_issue_addr  = addr_r;
  assign mem_issue_wdata = wdata_r;
  assign resp_valid      = (state == ST_RESPOND);
  assign resp_op         = op_r;
  assign resp_rdata      = rdata_r;                // Don't-care for writes

endmodule : cache_core

//--- hdl/cache_pkg.sv
// Shared definitions for the kernel cache
// Fixed widths plus the opcode and core state encodings

package cache_pkg;

  // ------------------------------------------------
  // Fixed widths
  // ------------------------------------------------
  localparam int ADDR_W = 16;                 // Word address bits
  localparam int DATA_W = 32;                 // Word data bits

  // ------------------------------------------------
  // Request opcode
  // ------------------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,                          // Word read
    OP_WRITE = 1'b1                           // Word write, goes through to memory
  } cache_op_e;

  // ------------------------------------------------
  // Core FSM states
  // ------------------------------------------------
  typedef enum logic [2:0] {
    ST_INIT      = 3'd0,                      // Sweep valid bits after reset
    ST_IDLE      = 3'd1,                      // Wait for a queued request
    ST_LOOKUP    = 3'd2,                      // Tag compare on the latched address
    ST_MEM_ISSUE = 3'd3,                      // Send to memory once a credit is free
    ST_MEM_WAIT  = 3'd4,                      // Wait for read fill data
    ST_RESPOND   = 3'd5                       // Drive one kernel response
  } core_state_e;

endpackage : cache_pkg

//--- hdl/cache_request_ingress.sv
// Kernel request queue
// Circular buffer that hands one kernel credit back for every pop
`timescale 1ns/10ps

module cache_request_ingress import cache_pkg::*; #(
  parameter int REQ_DEPTH = 4                 // Entries, equal to kernel credits
) (
  input  logic              ap_clk,
  input  logic              areset_core,
  input  logic              req_valid,
  input  cache_op_e         req_op,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  input  logic              q_pop,
  output logic              q_valid,
  output cache_op_e         q_op,
  output logic [ADDR_W-1:0] q_addr,
  output logic [DATA_W-1:0] q_wdata,
  output logic              req_credit
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  cache_op_e         op_q   [REQ_DEPTH];      // Queue storage
  logic [ADDR_W-1:0] addr_q [REQ_DEPTH];
  logic [DATA_W-1:0] data_q [REQ_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;                   // Occupied entries

  // Wraps at REQ_DEPTH so odd depths work too
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------------------------
  // Pointers, occupancy and credit return
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_core) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (req_valid) wr_ptr <= ptr_next(wr_ptr);   // Kernel never overruns its credits
      if (q_pop)     rd_ptr <= ptr_next(rd_ptr);
      case ({req_valid, q_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                   // Both or neither
      endcase
      req_credit <= q_pop;                         // Credit one cycle after pop
    end
  end

  always_ff @(posedge ap_clk) begin
    if (req_valid) begin
      op_q[wr_ptr]   <= req_op;
      addr_q[wr_ptr] <= req_addr;
      data_q[wr_ptr] <= req_wdata;
    end
  end

  assign q_valid = (count != '0);                  // Head visible the cycle after write
  assign q_op    = op_q[rd_ptr];
  assign q_addr  = addr_q[rd_ptr];
  assign q_wdata = data_q[rd_ptr];

endmodule : cache_request_ingress

//--- hdl/kernel_cache.sv
// Kernel cache top level
// Registers reset and links the request queue, cache core and memory port
`timescale 1ns/10ps

module kernel_cache import cache_pkg::*; #(
  parameter int REQ_DEPTH   = 4,              // Kernel queue depth and kernel credits
  parameter int NUM_LINES   = 16,             // Direct-mapped lines, power of two
  parameter int MEM_CREDITS = 2               // Initial memory credits
) (
  input  logic              ap_clk,
  input  logic              areset_control,
  // Kernel request side
  input  logic              req_valid,
  input  cache_op_e         req_op,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              req_credit,
  // Kernel response side
  output logic              resp_valid,
  output cache_op_e         resp_op,
  output logic [DATA_W-1:0] resp_rdata,
  output logic              cache_setup,
  // Backend memory side
  output logic              mem_req_valid,
  output cache_op_e         mem_req_op,
  output logic [ADDR_W-1:0] mem_req_addr,
  output logic [DATA_W-1:0] mem_req_wdata,
  input  logic              mem_credit,
  input  logic              mem_rdata_valid,
  input  logic [DATA_W-1:0] mem_rdata
);

  // ------------------------------------------------
  // Internal links
  // ------------------------------------------------
  logic              areset_core;             // Registered reset for all blocks
  logic              q_valid;
  cache_op_e         q_op;
  logic [ADDR_W-1:0] q_addr;
  logic [DATA_W-1:0] q_wdata;
  logic              q_pop;
  logic              mem_issue;
  cache_op_e         mem_issue_op;
  logic [ADDR_W-1:0] mem_issue_addr;
  logic [DATA_W-1:0] mem_issue_wdata;
  logic              mem_can_issue;
  logic              fill_valid;
  logic [DATA_W-1:0] fill_data;

  // One register stage on reset before fan-out
  always_ff @(posedge ap_clk) begin
    areset_core <= areset_control;
  end

  cache_request_ingress #(.REQ_DEPTH(REQ_DEPTH)) u_ingress (.*);

  cache_core #(.NUM_LINES(NUM_LINES)) u_core (.*);

  memory_port #(.MEM_CREDITS(MEM_CREDITS)) u_mem_port (.*);

endmodule : kernel_cache

//--- hdl/memory_port.sv
// Backend memory port
// Memory credit counter with registered request and read data paths
`timescale 1ns/10ps

module memory_port import cache_pkg::*; #(
  parameter int MEM_CREDITS = 2               // Requests memory can hold
) (
  input  logic              ap_clk,
  input  logic              areset_core,
  input  logic              mem_issue,
  input  cache_op_e         mem_issue_op,
  input  logic [ADDR_W-1:0] mem_issue_addr,
  input  logic [DATA_W-1:0] mem_issue_wdata,
  output logic              mem_can_issue,
  output logic              mem_req_valid,
  output cache_op_e         mem_req_op,
  output logic [ADDR_W-1:0] mem_req_addr,
  output logic [DATA_W-1:0] mem_req_wdata,
  input  logic              mem_credit,
  input  logic              mem_rdata_valid,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              fill_valid,
  output logic [DATA_W-1:0] fill_data
);

  localparam int CNT_W = $clog2(MEM_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;               // Credits held toward memory

  assign mem_can_issue = (credit_cnt != '0) && !mem_req_valid;  // Request register free

  // ------------------------------------------------
  // Credit count and valid flags
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_core) begin
      credit_cnt    <= CNT_W'(MEM_CREDITS);
      mem_req_valid <= 1'b0;
      fill_valid    <= 1'b0;
    end else begin
      case ({mem_issue, mem_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spent on issue
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Returned on retire
        default: credit_cnt <= credit_cnt;
      endcase
      mem_req_valid <= mem_issue;
      fill_valid    <= mem_rdata_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (mem_issue) begin
      mem_req_op    <= mem_issue_op;
      mem_req_addr  <= mem_issue_addr;
      mem_req_wdata <= mem_issue_wdata;
    end
    fill_data <= mem_rdata;
  end

endmodule : memory_port

//--- run_sim.sh
#!/bin/sh
# Build and run the kernel cache testbench with Verilator
rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module kernel_cache_tb \
  -Mdir obj_dir -o kernel_cache_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/kernel_cache_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without passing"; exit 1; }
exit 0

//--- tb.f
hdl/cache_pkg.sv
hdl/cache_request_ingress.sv
hdl/cache_core.sv
hdl/memory_port.sv
hdl/kernel_cache.sv
verification/kernel_cache_props.sv
verification/kernel_cache_tb.sv

//--- verification/kernel_cache_props.sv
// Bound checks for the kernel cache
// Credit accounting toward memory and kernel credit quiet during reset
`timescale 1ns/10ps

module kernel_cache_props #(
  parameter int MEM_CREDITS = 2,              // Start value of the memory credit count
  parameter int CNT_W       = 2
) (
  input logic             ap_clk,
  input logic             areset_core,
  input logic [CNT_W-1:0] credit_cnt,
  input logic             mem_req_valid,
  input logic             req_credit
);

  // Count only grows back to its start value
  credit_bound: assert property (@(posedge ap_clk) disable iff (areset_core)
    credit_cnt <= CNT_W'(MEM_CREDITS)) else $error("memory credit count above its start value");

  // Request leaves one cycle after an issue that held a credit
  req_has_credit: assert property (@(posedge ap_clk) disable iff (areset_core)
    mem_req_valid |-> $past(credit_cnt) != '0) else $error("memory request without a credit");

  // Nothing handed back to the kernel while in reset
  credit_quiet: assert property (@(posedge ap_clk)
    areset_core |=> !req_credit) else $error("kernel credit returned during reset");

endmodule : kernel_cache_props

bind memory_port kernel_cache_props #(.MEM_CREDITS(MEM_CREDITS), .CNT_W(CNT_W)) props_mem (
  .ap_clk, .areset_core, .credit_cnt, .mem_req_valid, .req_credit(1'b0));

bind cache_request_ingress kernel_cache_props #(.MEM_CREDITS(1), .CNT_W(1)) props_ingress (
  .ap_clk, .areset_core, .credit_cnt(1'b0), .mem_req_valid(1'b0), .req_credit);

//--- verification/kernel_cache_tb.sv
// Kernel cache testbench
// Random kernel traffic against a backend memory model and a cache hit model
`timescale 1ns/10ps

module kernel_cache_tb import cache_pkg::*; ();

  localparam int REQ_DEPTH   = 4;
  localparam int NUM_LINES   = 16;
  localparam int MEM_CREDITS = 2;
  localparam int IDX_W       = $clog2(NUM_LINES);
  localparam int MEM_AW      = 10;            // Backing store covers addresses below 1024
  localparam int NUM_RANDOM  = 300;

  logic              ap_clk = 1'b0;
  logic              areset_control;
  logic              req_valid;
  cache_op_e         req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic              req_credit;
  logic              resp_valid;
  cache_op_e         resp_op;
  logic [DATA_W-1:0] resp_rdata;
  logic              cache_setup;
  logic              mem_req_valid;
  cache_op_e         mem_req_op;
  logic [ADDR_W-1:0] mem_req_addr;
  logic [DATA_W-1:0] mem_req_wdata;
  logic              mem_credit;
  logic              mem_rdata_valid;
  logic [DATA_W-1:0] mem_rdata;

  kernel_cache #(
    .REQ_DEPTH(REQ_DEPTH), .NUM_LINES(NUM_LINES), .MEM_CREDITS(MEM_CREDITS)
  ) dut (.*);

  always #20 ap_clk = ~ap_clk;                // 40 ns period

  // --------------------------------------------------
  // Model state
  // --------------------------------------------------
  logic [31:0]       rng_state = 32'hbf93_d665;
  logic [DATA_W-1:0] back_mem [1 << MEM_AW];  // Backend contents
  logic [DATA_W-1:0] view_mem [1 << MEM_AW];  // Kernel view at send time
  logic              line_ok  [NUM_LINES];
  logic [ADDR_W-1:0] line_addr [NUM_LINES];   // Full address held by each line
  cache_op_e         exp_resp_op [$];
  logic [DATA_W-1:0] exp_resp_data [$];
  cache_op_e         exp_mem_op [$];
  logic [ADDR_W-1:0] exp_mem_addr [$];
  logic [DATA_W-1:0] exp_mem_data [$];
  cache_op_e         pend_op [$];             // Requests held by memory
  logic [ADDR_W-1:0] pend_addr [$];
  logic [DATA_W-1:0] pend_data [$];
  int                pend_ready [$];          // Cycle each may retire
  int                credits;
  int                cyc;
  int                hits;
  logic              hold;                    // Withholds memory retires

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
    return {addr ^ 16'h5a3c, ~addr} ^ 32'h0f1e_2d3c;
  endfunction

  task automatic stop_fail(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_resp(input cache_op_e exp_op, input cache_op_e got_op,
                            input logic [DATA_W-1:0] exp_data, input logic [DATA_W-1:0] got_data);
    if (got_op !== exp_op)
      stop_fail($sformatf("FAIL at %0t: response op %s, expected %s",
                          $time, got_op.name(), exp_op.name()));
    else if (exp_op == OP_READ && got_data !== exp_data)
      stop_fail($sformatf("FAIL at %0t: read data %h, expected %h", $time, got_data, exp_data));
  endtask

  task automatic check_mem_req(input cache_op_e exp_op, input cache_op_e got_op,
                               input logic [ADDR_W-1:0] exp_addr, input logic [ADDR_W-1:0] got_addr,
                               input logic [DATA_W-1:0] exp_data, input logic [DATA_W-1:0] got_data);
    if (got_op !== exp_op || got_addr !== exp_addr)
      stop_fail($sformatf("FAIL at %0t: memory %s at %h, expected %s at %h", $time,
                          got_op.name(), got_addr, exp_op.name(), exp_addr));
    else if (exp_op == OP_WRITE && got_data !== exp_data)
      stop_fail($sformatf("FAIL at %0t: memory write data %h, expected %h",
                          $time, got_data, exp_data));
  endtask

  // --------------------------------------------------
  // One clock: sample outputs and drive inputs on the falling edge
  // --------------------------------------------------
  task automatic step();
    @(negedge ap_clk);
    cyc++;
    req_valid       = 1'b0;
    mem_credit      = 1'b0;
    mem_rdata_valid = 1'b0;
    if (req_credit) credits++;
    if (credits > REQ_DEPTH) stop_fail("Cache returned more kernel credits than were spent");
    if (resp_valid) begin
      if (exp_resp_op.size() == 0) stop_fail("Response arrived with no request outstanding");
      else check_resp(exp_resp_op.pop_front(), resp_op, exp_resp_data.pop_front(), resp_rdata);
    end
    if (mem_req_valid) begin
      if (exp_mem_op.size() == 0) stop_fail("Memory request with no miss or write pending");
      else begin
        check_mem_req(exp_mem_op.pop_front(), mem_req_op, exp_mem_addr.pop_front(),
                      mem_req_addr, exp_mem_data.pop_front(), mem_req_wdata);
        pend_op.push_back(mem_req_op);
        pend_addr.push_back(mem_req_addr);
        pend_data.push_back(mem_req_wdata);
        pend_ready.push_back(cyc + 1 + int'(next_random() % 6));  // Random latency
      end
      if (pend_op.size() > MEM_CREDITS) stop_fail("Memory got more requests than credits");
    end
    if (!hold && pend_op.size() != 0 && cyc >= pend_ready[0]) begin
      mem_credit = 1'b1;                      // Retire head in order
      if (pend_op[0] == OP_WRITE) begin
        back_mem[pend_addr[0][MEM_AW-1:0]] = pend_data[0];
      end else begin
        mem_rdata_valid = 1'b1;
        mem_rdata       = back_mem[pend_addr[0][MEM_AW-1:0]];
      end
      void'(pend_op.pop_front());
      void'(pend_addr.pop_front());
      void'(pend_data.pop_front());
      void'(pend_ready.pop_front());
    end
  endtask

  // Drive one request now and predict its memory traffic and response
  task automatic issue_req(input cache_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    logic [IDX_W-1:0] idx;
    idx       = addr[IDX_W-1:0];
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = data;
    credits--;
    if (op == OP_WRITE) begin                 // Through to memory, no allocate
      exp_mem_op.push_back(OP_WRITE);
      exp_mem_addr.push_back(addr);
      exp_mem_data.push_back(data);
      view_mem[addr[MEM_AW-1:0]] = data;
    end else if (line_ok[idx] && line_addr[idx] == addr) begin
      hits++;
    end else begin                            // Miss fetches and installs
      exp_mem_op.push_back(OP_READ);
      exp_mem_addr.push_back(addr);
      exp_mem_data.push_back('0);
      line_ok[idx]   = 1'b1;
      line_addr[idx] = addr;
    end
    exp_resp_op.push_back(op);
    exp_resp_data.push_back(view_mem[addr[MEM_AW-1:0]]);
  endtask

  task automatic send_req(input cache_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    step();
    while (credits == 0 || cache_setup) begin
      waited++;
      if (waited > 500) stop_fail("Timeout waiting for a kernel credit");
      else step();
    end
    issue_req(op, addr, data);
  endtask

  task automatic pick_req(output cache_op_e op, output logic [ADDR_W-1:0] addr,
                          output logic [DATA_W-1:0] data);
    logic [31:0] rnd;
    rnd  = next_random();
    op   = (rnd[3:0] < 4'd5) ? OP_WRITE : OP_READ;   // About a third writes
    addr = rnd[31:16] % 16'd48;                      // Small range so lines get reused
    data = next_random();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_resp_op.size() != 0 || pend_op.size() != 0) begin
      waited++;
      if (waited > 2000) stop_fail("Timeout waiting for outstanding responses");
      else step();
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int                waited;
    cache_op_e         op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    $timeformat(-9, 0, " ns", 0);
    areset_control  = 1'b1;
    req_valid       = 1'b0;
    req_op          = OP_READ;
    req_addr        = '0;
    req_wdata       = '0;
    mem_credit      = 1'b0;
    mem_rdata_valid = 1'b0;
    mem_rdata       = '0;
    credits         = REQ_DEPTH;
    cyc             = 0;
    hits            = 0;
    hold            = 1'b0;
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      back_mem[i] = init_word(ADDR_W'(i));
      view_mem[i] = back_mem[i];
    end
    for (int i = 0; i < NUM_LINES; i++) line_ok[i] = 1'b0;
    repeat (16) step();
    areset_control = 1'b0;
    step();
    if (cache_setup !== 1'b1) stop_fail("cache_setup was not high after reset");
    waited = 0;
    while (cache_setup) begin                 // Step flags any early response or request
      waited++;
      if (waited > NUM_LINES + 8) stop_fail("Timeout waiting for cache_setup to fall");
      else step();
    end
    send_req(OP_WRITE, 16'h0025, 32'hcafe_0025);
    send_req(OP_READ, 16'h0025, '0);          // Miss returns the written word
    send_req(OP_READ, 16'h0025, '0);          // Hit
    send_req(OP_READ, 16'h0035, '0);          // Same line, evicts
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (next_random() % 3 == 0) step();
      pick_req(op, addr, data);
      send_req(op, addr, data);
    end
    drain();
    hold = 1'b1;
    send_req(OP_WRITE, 16'h0107, 32'h0bad_0107);  // Two writes take every memory credit
    send_req(OP_WRITE, 16'h0108, 32'h0bad_0108);
    send_req(OP_READ, 16'h0107, '0);          // Miss with no credit parks the core in ST_MEM_ISSUE
    for (int i = 0; i < 60; i++) begin
      step();
      pick_req(op, addr, data);
      if (credits > 0) issue_req(op, addr, data);
    end
    if (credits != 0) stop_fail("Kernel still held credits while memory was stalled");
    else if (pend_op.size() != MEM_CREDITS)
      stop_fail("Memory credits were not used up during the stall");
    hold = 1'b0;
    drain();
    if (exp_mem_op.size() != 0) stop_fail("Expected memory requests never appeared");
    else if (hits == 0) stop_fail("No read hit was exercised");
    else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule : kernel_cache_tb
